// File: hw/spi_defines.svh
`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

// sizes
`define SPI_NCS         4
`define SPI_FIFO_DEPTH  16
`define SPI_ADDR_W      8
`define SPI_DATA_W      32
`define SPI_CHAR_W      16

// register map
`define SPI_ADDR_SPMODE  8'h00
`define SPI_ADDR_SPIE    8'h04
`define SPI_ADDR_SPIM    8'h08
`define SPI_ADDR_SPCOM   8'h0C
`define SPI_ADDR_SPITF   8'h10
`define SPI_ADDR_SPIRF   8'h14
`define SPI_ADDR_CSMODE0 8'h20  // one word per select from here

`define SPI_SPMODE_EN    0
`define SPI_SPMODE_LOOP  1

`define SPI_IE_DON       0  // same positions in SPIM
`define SPI_IE_RNE       1
`define SPI_IE_OVF       2

`endif

// File: hw/spi_pkg.sv
`include "spi_defines.svh"

package spi_pkg;

    // right-aligned, upper bits zero for short characters
    typedef logic [`SPI_CHAR_W-1:0] spi_char_t;

    typedef logic [1:0] cs_idx_t;

    typedef struct packed {
        logic        cpol;     // idle sck level
        logic        cpha;     // 1 = sample on second edge
        logic        csn_pol;  // 1 = active low select
        logic        div16;
        logic [3:0]  pm;       // prescale - 1
        logic [3:0]  len;      // bits - 1
        logic [19:0] rsvd;
    } cs_mode_t;

    typedef struct packed {
        cs_idx_t     cs;
        logic [21:0] rsvd;
        logic [7:0]  tran_len;  // chars - 1
    } spcom_t;

    typedef enum logic [2:0] {
        IDLE,
        DATA_WAIT,
        SHIFT,
        DONE
    } frame_state_e;

endpackage

// File: hw/spi_frame_if.sv
`timescale 1ns/1ps

interface spi_frame_if
    import spi_pkg::*;
();
    logic       start;  // one cycle
    cs_mode_t   mode;   // mode of the commanded select
    cs_idx_t    cs;
    logic [7:0] tran_len;
    logic       loop;
    logic       busy;
    logic       done;   // one cycle, end of frame

    modport regs (
        output start, mode, cs, tran_len, loop,
        input  busy, done
    );

    modport engine (
        input  start, mode, cs, tran_len, loop,
        output busy, done
    );
endinterface

// File: hw/char_fifo.sv
`timescale 1ns/1ps
`include "spi_defines.svh"

module char_fifo #(
    parameter type payload_t = logic [`SPI_CHAR_W-1:0]
) (
    input  logic     S_SYSCLK,
    input  logic     S_RESETN,
    input  logic     i_push,
    input  payload_t i_data,
    input  logic     i_pop,
    output payload_t o_data,
    output logic     o_empty,
    output logic     o_full
);
    localparam int DEPTH = `SPI_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    assign o_empty = (count == '0);
    assign o_full  = (count == DEPTH[AW:0]);
    assign do_push = i_push && !o_full;   // dropped when full
    assign do_pop  = i_pop && !o_empty;
    assign o_data  = mem[rd_ptr];         // head, no read latency

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (do_push) mem[wr_ptr] <= i_data;
    end
endmodule

// File: hw/spi_axil_regs.sv
`timescale 1ns/1ps
`include "spi_defines.svh"

module spi_axil_regs
    import spi_pkg::*;
(
    input  logic                    S_SYSCLK,
    input  logic                    S_RESETN,
    input  logic [`SPI_ADDR_W-1:0]  i_awaddr,
    input  logic                    i_awvalid,
    output logic                    o_awready,
    input  logic [`SPI_DATA_W-1:0]  i_wdata,
    input  logic [`SPI_DATA_W/8-1:0] i_wstrb,
    input  logic                    i_wvalid,
    output logic                    o_wready,
    output logic [1:0]              o_bresp,
    output logic                    o_bvalid,
    input  logic                    i_bready,
    input  logic [`SPI_ADDR_W-1:0]  i_araddr,
    input  logic                    i_arvalid,
    output logic                    o_arready,
    output logic [`SPI_DATA_W-1:0]  o_rdata,
    output logic [1:0]              o_rresp,
    output logic                    o_rvalid,
    input  logic                    i_rready,
    output logic                    o_interrupt,
    spi_frame_if.regs               frame,
    output logic                    o_tx_push,
    output spi_char_t               o_tx_data,
    input  logic                    i_tx_full,
    output logic                    o_rx_pop,
    input  spi_char_t               i_rx_data,
    input  logic                    i_rx_empty,
    input  logic                    i_rx_ovf
);
    logic                   awready_q;
    logic                   arready_q;
    logic [`SPI_DATA_W-1:0] spmode;
    logic [`SPI_DATA_W-1:0] spim;
    logic [`SPI_DATA_W-1:0] spie;
    spcom_t                 spcom;
    cs_mode_t               cs_mode [`SPI_NCS];
    logic                   don_q;
    logic                   ovf_q;
    logic                   start_q;
    logic                   wr_ok;
    logic [`SPI_ADDR_W-1:0] cs_woff;
    logic [`SPI_ADDR_W-1:0] cs_roff;
    logic [`SPI_DATA_W-1:0] rd_mux;

    assign o_awready = awready_q;
    assign o_wready  = awready_q;  // both pulse together
    assign o_arready = arready_q;
    assign o_bresp   = 2'b00;      // always OKAY
    assign o_rresp   = 2'b00;

    assign wr_ok   = awready_q && (&i_wstrb);  // partial strobes ignored
    assign cs_woff = i_awaddr - `SPI_ADDR_CSMODE0;
    assign cs_roff = i_araddr - `SPI_ADDR_CSMODE0;

    assign o_tx_push = wr_ok && (i_awaddr == `SPI_ADDR_SPITF) && !i_tx_full;
    assign o_tx_data = i_wdata[`SPI_CHAR_W-1:0];
    assign o_rx_pop  = arready_q && (i_araddr == `SPI_ADDR_SPIRF);

    assign frame.start    = start_q;
    assign frame.mode     = cs_mode[spcom.cs];
    assign frame.cs       = spcom.cs;
    assign frame.tran_len = spcom.tran_len;
    assign frame.loop     = spmode[`SPI_SPMODE_LOOP];

    always_comb begin
        spie = '0;
        spie[`SPI_IE_DON] = don_q;
        spie[`SPI_IE_RNE] = !i_rx_empty;  // live
        spie[`SPI_IE_OVF] = ovf_q;
    end

    assign o_interrupt = |(spie & spim);

    always_comb begin
        case (i_araddr)
            `SPI_ADDR_SPMODE: rd_mux = spmode;
            `SPI_ADDR_SPIE:   rd_mux = spie;
            `SPI_ADDR_SPIM:   rd_mux = spim;
            `SPI_ADDR_SPCOM:  rd_mux = spcom;
            `SPI_ADDR_SPIRF:  rd_mux = i_rx_empty ? '0 : `SPI_DATA_W'(i_rx_data);
            default: begin
                if (cs_roff < (`SPI_NCS * 4)) rd_mux = cs_mode[cs_roff[3:2]];
                else rd_mux = '0;
            end
        endcase
    end

    // bus handshakes
    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            awready_q <= 1'b0;
            o_bvalid  <= 1'b0;
            arready_q <= 1'b0;
            o_rvalid  <= 1'b0;
            o_rdata   <= '0;
        end else begin
            awready_q <= i_awvalid && i_wvalid && !awready_q && !o_bvalid;
            if (awready_q) o_bvalid <= 1'b1;
            else if (i_bready) o_bvalid <= 1'b0;

            arready_q <= i_arvalid && !arready_q && !o_rvalid;
            if (arready_q) begin
                o_rvalid <= 1'b1;
                o_rdata  <= rd_mux;
            end else if (i_rready) begin
                o_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            spmode  <= '0;
            spim    <= '0;
            spcom   <= '0;
            don_q   <= 1'b0;
            ovf_q   <= 1'b0;
            start_q <= 1'b0;
            for (int i = 0; i < `SPI_NCS; i++) cs_mode[i] <= '0;
        end else begin
            start_q <= 1'b0;
            if (wr_ok) begin
                case (i_awaddr)
                    `SPI_ADDR_SPMODE: spmode <= i_wdata;
                    `SPI_ADDR_SPIM:   spim   <= i_wdata;
                    `SPI_ADDR_SPIE: begin  // write 1 to clear
                        if (i_wdata[`SPI_IE_DON]) don_q <= 1'b0;
                        if (i_wdata[`SPI_IE_OVF]) ovf_q <= 1'b0;
                    end
                    `SPI_ADDR_SPCOM: begin
                        if (spmode[`SPI_SPMODE_EN] && !frame.busy) begin
                            spcom   <= i_wdata;
                            start_q <= 1'b1;
                        end
                    end
                    default: begin
                        if (cs_woff < (`SPI_NCS * 4)) cs_mode[cs_woff[3:2]] <= i_wdata;
                    end
                endcase
            end
            // set wins over a clear in the same cycle
            if (frame.done) don_q <= 1'b1;
            if (i_rx_ovf) ovf_q <= 1'b1;
        end
    end
endmodule

// File: hw/spi_frame_engine.sv
`timescale 1ns/1ps
`include "spi_defines.svh"

module spi_frame_engine
    import spi_pkg::*;
(
    input  logic                S_SYSCLK,
    input  logic                S_RESETN,
    spi_frame_if.engine         frame,
    input  spi_char_t           i_tx_data,
    input  logic                i_tx_empty,
    output logic                o_tx_pop,
    output logic                o_rx_push,
    output spi_char_t           o_rx_data,
    input  logic                i_rx_full,
    output logic                o_rx_ovf,
    output logic                o_spi_sck,
    output logic                o_spi_mosi,
    input  logic                i_spi_miso,
    output logic [`SPI_NCS-1:0] o_spi_sel
);
    frame_state_e        state;
    logic [7:0]          half_cnt;
    logic [7:0]          half_top;
    logic                phase;     // 0 first half of a bit, 1 second half
    logic [3:0]          bit_cnt;
    logic [7:0]          char_cnt;
    spi_char_t           tx_sh;
    spi_char_t           rx_sh;
    logic [`SPI_NCS-1:0] sel_q;
    logic                half_tick;
    logic                mid_tick;
    logic                end_tick;
    logic                char_end;
    logic                rx_bit;

    // half bit is (pm+1) or 8*(pm+1) cycles
    assign half_top  = frame.mode.div16 ? {1'b0, frame.mode.pm, 3'b111}
                                        : {4'b0, frame.mode.pm};
    assign half_tick = (half_cnt == '0);
    assign mid_tick  = (state == SHIFT) && half_tick && !phase;  // sample edge
    assign end_tick  = (state == SHIFT) && half_tick && phase;   // shift edge
    assign char_end  = end_tick && (bit_cnt == frame.mode.len);

    assign o_spi_sck  = (state == SHIFT) ? (frame.mode.cpol ^ frame.mode.cpha ^ phase)
                                         : frame.mode.cpol;
    assign o_spi_mosi = (state == SHIFT) ? tx_sh[frame.mode.len] : 1'b0;
    assign rx_bit     = frame.loop ? o_spi_mosi : i_spi_miso;
    assign o_spi_sel  = sel_q;

    assign o_tx_pop   = (state == DATA_WAIT) && !i_tx_empty;
    assign o_rx_push  = char_end && !i_rx_full;
    assign o_rx_ovf   = char_end && i_rx_full;
    assign o_rx_data  = rx_sh;

    assign frame.busy = (state != IDLE);
    assign frame.done = (state == DONE);

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            state    <= IDLE;
            half_cnt <= '0;
            phase    <= 1'b0;
            bit_cnt  <= '0;
            char_cnt <= '0;
            sel_q    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (frame.start) begin
                        state    <= DATA_WAIT;
                        char_cnt <= '0;
                        sel_q[frame.cs] <= ~frame.mode.csn_pol;  // assert
                    end
                end
                DATA_WAIT: begin  // sck rests at cpol until a char is queued
                    if (!i_tx_empty) begin
                        state    <= SHIFT;
                        half_cnt <= half_top;
                        phase    <= 1'b0;
                        bit_cnt  <= '0;
                    end
                end
                SHIFT: begin
                    if (half_tick) begin
                        half_cnt <= half_top;
                        phase    <= ~phase;
                    end else begin
                        half_cnt <= half_cnt - 1'b1;
                    end
                    if (char_end) begin
                        if (char_cnt == frame.tran_len) begin
                            state <= DONE;
                            sel_q[frame.cs] <= frame.mode.csn_pol;  // release with done
                        end else begin
                            state    <= DATA_WAIT;
                            char_cnt <= char_cnt + 1'b1;
                        end
                    end else if (end_tick) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // shift registers, msb first
    always_ff @(posedge S_SYSCLK) begin
        if (o_tx_pop) begin
            tx_sh <= i_tx_data;
            rx_sh <= '0;  // keeps short chars right-aligned
        end else begin
            if (end_tick) tx_sh <= {tx_sh[`SPI_CHAR_W-2:0], 1'b0};
            if (mid_tick) rx_sh <= {rx_sh[`SPI_CHAR_W-2:0], rx_bit};
        end
    end
endmodule

// File: hw/spi_master_top.sv
`timescale 1ns/1ps
`include "spi_defines.svh"

module spi_master_top
    import spi_pkg::*;
(
    input  logic                     S_SYSCLK,
    input  logic                     S_RESETN,
    input  logic [`SPI_ADDR_W-1:0]   i_awaddr,
    input  logic                     i_awvalid,
    output logic                     o_awready,
    input  logic [`SPI_DATA_W-1:0]   i_wdata,
    input  logic [`SPI_DATA_W/8-1:0] i_wstrb,
    input  logic                     i_wvalid,
    output logic                     o_wready,
    output logic [1:0]               o_bresp,
    output logic                     o_bvalid,
    input  logic                     i_bready,
    input  logic [`SPI_ADDR_W-1:0]   i_araddr,
    input  logic                     i_arvalid,
    output logic                     o_arready,
    output logic [`SPI_DATA_W-1:0]   o_rdata,
    output logic [1:0]               o_rresp,
    output logic                     o_rvalid,
    input  logic                     i_rready,
    output logic                     o_interrupt,
    output logic                     o_spi_sck,
    output logic                     o_spi_mosi,
    input  logic                     i_spi_miso,
    output logic [`SPI_NCS-1:0]      o_spi_sel
);
    spi_char_t tx_push_data;
    spi_char_t tx_head;
    spi_char_t rx_push_data;
    spi_char_t rx_head;
    logic      tx_push;
    logic      tx_pop;
    logic      tx_empty;
    logic      tx_full;
    logic      rx_push;
    logic      rx_pop;
    logic      rx_empty;
    logic      rx_full;
    logic      rx_ovf;

    spi_frame_if frame_if ();

    spi_axil_regs u_regs (
        .S_SYSCLK    (S_SYSCLK),
        .S_RESETN    (S_RESETN),
        .i_awaddr    (i_awaddr),
        .i_awvalid   (i_awvalid),
        .o_awready   (o_awready),
        .i_wdata     (i_wdata),
        .i_wstrb     (i_wstrb),
        .i_wvalid    (i_wvalid),
        .o_wready    (o_wready),
        .o_bresp     (o_bresp),
        .o_bvalid    (o_bvalid),
        .i_bready    (i_bready),
        .i_araddr    (i_araddr),
        .i_arvalid   (i_arvalid),
        .o_arready   (o_arready),
        .o_rdata     (o_rdata),
        .o_rresp     (o_rresp),
        .o_rvalid    (o_rvalid),
        .i_rready    (i_rready),
        .o_interrupt (o_interrupt),
        .frame       (frame_if.regs),
        .o_tx_push   (tx_push),
        .o_tx_data   (tx_push_data),
        .i_tx_full   (tx_full),
        .o_rx_pop    (rx_pop),
        .i_rx_data   (rx_head),
        .i_rx_empty  (rx_empty),
        .i_rx_ovf    (rx_ovf)
    );

    char_fifo #(.payload_t(spi_char_t)) u_tx_fifo (
        .S_SYSCLK (S_SYSCLK),
        .S_RESETN (S_RESETN),
        .i_push   (tx_push),
        .i_data   (tx_push_data),
        .i_pop    (tx_pop),
        .o_data   (tx_head),
        .o_empty  (tx_empty),
        .o_full   (tx_full)
    );

    char_fifo #(.payload_t(spi_char_t)) u_rx_fifo (
        .S_SYSCLK (S_SYSCLK),
        .S_RESETN (S_RESETN),
        .i_push   (rx_push),
        .i_data   (rx_push_data),
        .i_pop    (rx_pop),
        .o_data   (rx_head),
        .o_empty  (rx_empty),
        .o_full   (rx_full)
    );

    spi_frame_engine u_engine (
        .S_SYSCLK   (S_SYSCLK),
        .S_RESETN   (S_RESETN),
        .frame      (frame_if.engine),
        .i_tx_data  (tx_head),
        .i_tx_empty (tx_empty),
        .o_tx_pop   (tx_pop),
        .o_rx_push  (rx_push),
        .o_rx_data  (rx_push_data),
        .i_rx_full  (rx_full),
        .o_rx_ovf   (rx_ovf),
        .o_spi_sck  (o_spi_sck),
        .o_spi_mosi (o_spi_mosi),
        .i_spi_miso (i_spi_miso),
        .o_spi_sel  (o_spi_sel)
    );
endmodule

// File: testbench/spi_master_tb.sv
`timescale 1ns/1ps
`include "spi_defines.svh"

module spi_master_tb
    import spi_pkg::*;
();
    typedef struct packed {
        logic [1:0]  cs;
        logic        cpol;
        logic        cpha;
        logic        csn_pol;
        logic        div16;
        logic [3:0]  pm;
        logic [3:0]  len;
        logic        loop;
        logic [7:0]  n;     // characters in the frame
        logic [63:0] tx;    // char i at [16*i +: 16]
        logic [63:0] rx;    // slave responses in the same layout
    } row_t;

    logic S_SYSCLK, S_RESETN;
    logic [7:0] i_awaddr, i_araddr;
    logic i_awvalid, i_wvalid, i_bready, i_arvalid, i_rready, i_spi_miso;
    logic [31:0] i_wdata;
    logic [3:0] i_wstrb;
    logic o_awready, o_wready, o_bvalid, o_arready, o_rvalid, o_interrupt;
    logic [1:0] o_bresp, o_rresp;
    logic [31:0] o_rdata;
    logic o_spi_sck, o_spi_mosi;
    logic [`SPI_NCS-1:0] o_spi_sel;

    row_t rows [$];
    row_t cur;
    int errors = 0;
    bit timed_out = 0;
    string timeout_what;
    logic mon_on = 0;
    logic prev_sck = 0;
    int nb, ci;
    spi_char_t bits;
    spi_char_t mosi_q [$];
    logic [`SPI_NCS-1:0] exp_sel = '0;  // idle level of each select

    spi_master_top UUT (.*);

    initial begin
        S_SYSCLK = 0;
        forever #2 S_SYSCLK = ~S_SYSCLK;
    end

    task automatic check_word(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_char(string what, spi_char_t got, spi_char_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(string what, logic got, logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic stall_on_timeout(string what);
        timeout_what = what;
        timed_out = 1;
        forever @(posedge S_SYSCLK);
    endtask

    initial begin
        wait (timed_out);
        $display("timeout while waiting for %s", timeout_what);
        $display("Checks failed");
        $finish;
    end

    task automatic axi_write(logic [7:0] addr, logic [31:0] data, logic [3:0] strb = 4'hf);
        int t;
        @(posedge S_SYSCLK);
        i_awaddr <= addr;
        i_wdata <= data;
        i_wstrb <= strb;
        i_awvalid <= 1;
        i_wvalid <= 1;
        t = 0;
        do begin
            @(posedge S_SYSCLK);
            if (++t > 100) stall_on_timeout("AWREADY");
        end while (!o_awready);
        check_bit("wready with awready", o_wready, 1'b1);
        i_awvalid <= 0;
        i_wvalid <= 0;
        t = 0;
        do begin
            @(posedge S_SYSCLK);
            if (++t > 100) stall_on_timeout("BVALID");
        end while (!o_bvalid);
        check_word("bresp", 32'(o_bresp), 0);
    endtask

    task automatic axi_read(logic [7:0] addr, output logic [31:0] data);
        int t;
        @(posedge S_SYSCLK);
        i_araddr <= addr;
        i_arvalid <= 1;
        t = 0;
        do begin
            @(posedge S_SYSCLK);
            if (++t > 100) stall_on_timeout("ARREADY");
        end while (!o_arready);
        i_arvalid <= 0;
        t = 0;
        do begin
            @(posedge S_SYSCLK);
            if (++t > 100) stall_on_timeout("RVALID");
        end while (!o_rvalid);
        data = o_rdata;
        check_word("rresp", 32'(o_rresp), 0);
    endtask

    task automatic wait_don();
        logic [31:0] v;
        int t;
        t = 0;
        do begin
            axi_read(`SPI_ADDR_SPIE, v);
            if (++t > 500) stall_on_timeout("DON");
        end while (!v[`SPI_IE_DON]);
    endtask

    function automatic spi_char_t len_mask(logic [3:0] len);
        return spi_char_t'((17'h1 << (len + 1)) - 1);
    endfunction

    function automatic logic miso_for(int c, int b);
        spi_char_t ch;
        if (c >= int'(cur.n)) return 1'b0;
        ch = cur.rx[16*c +: 16];
        return ch[int'(cur.len) - b];
    endfunction

    // slave model sees sck and mosi as settled before this edge
    always @(posedge S_SYSCLK) begin
        if (mon_on) begin
            if (o_spi_sck != prev_sck && o_spi_sck == ~(cur.cpol ^ cur.cpha)) begin
                for (int k = 0; k < `SPI_NCS; k++)
                    check_bit("select in frame", o_spi_sel[k],
                              (k == cur.cs) ? ~cur.csn_pol : exp_sel[k]);
                bits = {bits[14:0], o_spi_mosi};
                nb++;
                if (nb == int'(cur.len) + 1) begin
                    mosi_q.push_back(bits);
                    bits = '0;
                    nb = 0;
                    ci++;
                end
                i_spi_miso <= miso_for(ci, nb);  // next bit before next sample edge
            end
        end
        prev_sck = o_spi_sck;
    end

    task automatic add_row(logic [1:0] cs, logic cpol, logic cpha, logic csn, logic div16,
                           logic [3:0] pm, logic [3:0] len, logic loop, logic [7:0] n,
                           logic [63:0] tx, logic [63:0] rx);
        row_t r;
        r = '{cs, cpol, cpha, csn, div16, pm, len, loop, n, tx, rx};
        rows.push_back(r);
    endtask

    task automatic run_row(row_t r);
        cs_mode_t m;
        logic [31:0] v;
        spi_char_t exp;
        m = '0;
        m.cpol = r.cpol;
        m.cpha = r.cpha;
        m.csn_pol = r.csn_pol;
        m.div16 = r.div16;
        m.pm = r.pm;
        m.len = r.len;
        axi_write(`SPI_ADDR_CSMODE0 + 8'(4 * r.cs), 32'(m));
        axi_read(`SPI_ADDR_CSMODE0 + 8'(4 * r.cs), v);
        check_word("csmode readback", v, 32'(m));
        axi_write(`SPI_ADDR_SPMODE, {30'b0, r.loop, 1'b1});
        for (int i = 0; i < int'(r.n); i++) axi_write(`SPI_ADDR_SPITF, 32'(r.tx[16*i +: 16]));
        cur = r;
        nb = 0;
        ci = 0;
        bits = '0;
        mosi_q.delete();
        i_spi_miso <= r.rx[r.len];
        axi_write(`SPI_ADDR_SPCOM, {r.cs, 22'b0, r.n - 8'd1});
        mon_on <= 1;  // sck idle level follows the new select from here
        axi_write(`SPI_ADDR_SPCOM, {r.cs ^ 2'd1, 22'b0, 8'd0});  // ignored while busy
        wait_don();
        mon_on <= 0;
        exp_sel[r.cs] = r.csn_pol;
        check_bit("interrupt on done", o_interrupt, 1);
        check_bit("sck idle", o_spi_sck, r.cpol);
        for (int k = 0; k < `SPI_NCS; k++)
            check_bit("select after frame", o_spi_sel[k], exp_sel[k]);
        axi_read(`SPI_ADDR_SPCOM, v);
        check_word("spcom kept", v, {r.cs, 22'b0, r.n - 8'd1});
        check_word("mosi char count", 32'(mosi_q.size()), 32'(r.n));
        for (int i = 0; i < int'(r.n) && i < mosi_q.size(); i++)
            check_char("mosi char", mosi_q[i], r.tx[16*i +: 16] & len_mask(r.len));
        for (int i = 0; i < int'(r.n); i++) begin
            axi_read(`SPI_ADDR_SPIRF, v);
            exp = r.loop ? r.tx[16*i +: 16] : r.rx[16*i +: 16];
            check_char("spirf char", v[15:0], exp & len_mask(r.len));
        end
        axi_read(`SPI_ADDR_SPIE, v);
        check_word("spie after reads", v, 32'h1);  // only DON left once RNE clears
        axi_write(`SPI_ADDR_SPIE, 32'h1);
        check_bit("interrupt cleared", o_interrupt, 0);
        axi_read(`SPI_ADDR_SPIE, v);
        check_word("spie cleared", v, 0);
    endtask

    initial begin
        logic [31:0] v;
        cs_mode_t m;
        S_RESETN = 0;
        {i_awaddr, i_araddr, i_wdata, i_wstrb} = '0;
        {i_awvalid, i_wvalid, i_arvalid, i_spi_miso} = '0;
        i_bready = 1;
        i_rready = 1;
        repeat (3) @(posedge S_SYSCLK);
        S_RESETN <= 1;

        check_bit("interrupt after reset", o_interrupt, 0);
        check_bit("sck after reset", o_spi_sck, 0);
        check_word("select after reset", 32'(o_spi_sel), 0);
        axi_read(`SPI_ADDR_SPMODE, v);
        check_word("spmode reset", v, 0);
        axi_read(`SPI_ADDR_SPIM, v);
        check_word("spim reset", v, 0);
        axi_read(`SPI_ADDR_SPIE, v);
        check_word("spie reset", v, 0);
        axi_write(`SPI_ADDR_SPIM, 32'h1);
        axi_write(`SPI_ADDR_SPIM, 32'h7, 4'h3);  // partial strobe has no effect
        axi_read(`SPI_ADDR_SPIM, v);
        check_word("spim readback", v, 32'h1);

        add_row(0, 0, 0, 0, 0, 1, 7, 1, 3, 64'h0000_01ff_003c_00a5, 64'h0);
        add_row(1, 1, 1, 0, 0, 0, 15, 1, 2, 64'h0000_0000_beef_1234, 64'h0);
        add_row(2, 0, 1, 1, 0, 2, 7, 0, 4, 64'h0011_0022_0033_00c4, 64'h0081_007e_0055_00aa);
        add_row(3, 1, 0, 0, 1, 0, 11, 0, 2, 64'h0000_0000_0123_0abc, 64'h0000_0000_0f0f_0fed);
        add_row(0, 0, 0, 0, 0, 0, 3, 0, 4, 64'h0009_0006_000f_0003, 64'h0005_000a_0001_000e);
        add_row(1, 1, 0, 0, 0, 3, 4, 0, 3, 64'h0000_0011_000e_001b, 64'h0000_0003_001c_0015);
        foreach (rows[i]) run_row(rows[i]);

        // fill the receive FIFO with 8-bit characters then send one more
        m = '0;
        m.len = 4'd7;
        axi_write(`SPI_ADDR_CSMODE0, 32'(m));
        axi_write(`SPI_ADDR_SPMODE, 32'h3);
        for (int i = 0; i < `SPI_FIFO_DEPTH; i++) axi_write(`SPI_ADDR_SPITF, 32'(i * 3 + 1));
        axi_write(`SPI_ADDR_SPCOM, 32'(`SPI_FIFO_DEPTH - 1));
        wait_don();
        axi_read(`SPI_ADDR_SPIE, v);
        check_word("spie full", v, 32'h3);
        axi_write(`SPI_ADDR_SPIE, 32'h1);
        axi_write(`SPI_ADDR_SPITF, 32'h55);
        axi_write(`SPI_ADDR_SPCOM, 32'h0);
        wait_don();
        axi_read(`SPI_ADDR_SPIE, v);
        check_word("spie overflow", v, 32'h7);
        axi_write(`SPI_ADDR_SPIE, 32'h5);
        axi_read(`SPI_ADDR_SPIE, v);
        check_word("spie ovf cleared", v, 32'h2);
        for (int i = 0; i < `SPI_FIFO_DEPTH; i++) begin
            axi_read(`SPI_ADDR_SPIRF, v);
            check_char("drained char", v[15:0], spi_char_t'(i * 3 + 1));
        end
        axi_read(`SPI_ADDR_SPIE, v);
        check_word("spie drained", v, 0);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end
endmodule

// File: spi_master_top.f
+incdir+hw
hw/spi_pkg.sv
hw/spi_frame_if.sv
hw/char_fifo.sv
hw/spi_axil_regs.sv
hw/spi_frame_engine.sv
hw/spi_master_top.sv
testbench/spi_master_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f spi_master_top.f --top-module spi_master_tb

out=$(./obj_dir/Vspi_master_tb)
echo "$out"

if grep -qx "All checks passed" <<< "$out"; then
    exit 0
else
    exit 1
fi
